// ==== source/flash_pkg.sv ====
package flash_pkg;

    // ==============================
    // host command word
    // ==============================

    // host format is 0x0NNN0MMM
    // NNN = bytes sent from the write buffer, MMM = response bytes kept in the read buffer
    // both counts are limited to 9 bits
    typedef union packed {
        logic [31:0] raw;               // word as written by the host
        struct packed {
            logic [6:0] rsvd_hi;        // ignored
            logic [8:0] wr_bytes;       // bytes to shift out on mosi
            logic [6:0] rsvd_lo;        // ignored
            logic [8:0] rd_bytes;       // bytes to capture from miso
        } fields;
    } flash_cmd_u;

    // ==============================
    // sequencer states
    // ==============================

    // each value is a bit index into the one-hot state vector, not an encoding
    typedef enum logic [3:0] {
        IDLE          = 4'd0,
        START_CMD     = 4'd1,   // ss still high, primes the 1-cycle buffer read
        SEND_CMD      = 4'd2,
        FINISH_CMD    = 4'd3,
        RECEIVE_RSP   = 4'd4,
        START_BS_CMD  = 4'd5,
        SEND_BS_CMD   = 4'd6,
        FINISH_BS_CMD = 4'd7,
        READ_BS       = 4'd8,   // streamed bitstream read
        BS_DONE       = 4'd9    // end strobe, ss back high
    } seq_state_e;

    localparam int NUM_STATES = 10;     // width of the one-hot vector

    // bitstream read command is always 4 bytes, loaded into the write buffer
    // by the loader before it raises bs_start
    localparam int BS_CMD_BITS = 32;

endpackage

// ==== source/spi_bit_buffers.sv ====
`timescale 1ns/1ps

module spi_bit_buffers #(
    parameter int BUF_ADDR_W = 7                    // word address, 2**BUF_ADDR_W words
) (
    input  logic                  clk,
    input  logic                  loader_busy,      // loader owns the write port

    // host write port
    input  logic                  host_wr_en,
    input  logic [BUF_ADDR_W-1:0] host_wr_addr,
    input  logic [31:0]           host_wr_data,

    // loader write port
    input  logic                  loader_wr_en,
    input  logic [BUF_ADDR_W-1:0] loader_wr_addr,
    input  logic [31:0]           loader_wr_data,

    // serial side of the write buffer
    input  logic                  wbuf_rd_en,
    input  logic [11:0]           bit_addr,         // shared serial bit index
    output logic                  wbuf_bit,

    // serial side of the read buffer
    input  logic                  rbuf_wr_en,
    input  logic                  rbuf_bit_in,

    // host read port
    input  logic                  rbuf_rd_en,
    input  logic [BUF_ADDR_W-1:0] rbuf_rd_addr,
    output logic [31:0]           rbuf_rd_data
);

    localparam int DEPTH    = 2 ** BUF_ADDR_W;
    localparam int WORD_MSB = BUF_ADDR_W + 4;       // top of word index inside bit_addr

    // ==============================
    // write port selection
    // ==============================

    logic                  sel_wr_en;               // registered winner of the write port
    logic [BUF_ADDR_W-1:0] sel_wr_addr;
    logic [31:0]           sel_wr_data;
    logic [31:0]           sel_wr_data_rev;

    // host writes are simply dropped while the loader holds the port
    always_ff @(posedge clk) begin
        if (loader_busy) begin
            sel_wr_en   <= loader_wr_en;
            sel_wr_addr <= loader_wr_addr;
            sel_wr_data <= loader_wr_data;
        end else begin
            sel_wr_en   <= host_wr_en;
            sel_wr_addr <= host_wr_addr;
            sel_wr_data <= host_wr_data;
        end
    end

    // word bit 31 goes to bit 0, i.e. the lowest serial address, so it leaves first
    assign sel_wr_data_rev = {<<{sel_wr_data}};

    // ==============================
    // write buffer, 32 in / 1 out
    // ==============================

    logic [31:0] wbuf_mem [DEPTH];

    always_ff @(posedge clk) begin
        if (sel_wr_en) begin
            wbuf_mem[sel_wr_addr] <= sel_wr_data_rev;
        end
    end

    // synchronous 1-bit read, data follows one cycle after the enable
    always_ff @(posedge clk) begin
        if (wbuf_rd_en) begin
            wbuf_bit <= wbuf_mem[bit_addr[WORD_MSB:5]][bit_addr[4:0]];
        end
    end

    // ==============================
    // read buffer, 1 in / 32 out
    // ==============================

    logic [31:0] rbuf_mem [DEPTH];
    logic [31:0] rbuf_word;                         // raw word, first bit in bit 0

    // one miso bit per cycle at the serial index
    always_ff @(posedge clk) begin
        if (rbuf_wr_en) begin
            rbuf_mem[bit_addr[WORD_MSB:5]][bit_addr[4:0]] <= rbuf_bit_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rbuf_rd_en) begin
            rbuf_word <= rbuf_mem[rbuf_rd_addr];
        end
    end

    // flip back so the first captured bit lands in bit 31
    assign rbuf_rd_data = {<<{rbuf_word}};

endmodule

// ==== source/flash_sequencer.sv ====
`timescale 1ns/1ps

module flash_sequencer import flash_pkg::*; #(
    parameter int BITSTREAM_BITS = 24090592         // bits in the streamed read
) (
    input  logic        clk,
    input  logic        bit_cnt_reset,              // sync reset, active high
    input  flash_cmd_u  cmd_word,
    input  logic        cmd_strobe,                 // single-cycle, only seen in IDLE
    input  logic        loader_busy,
    input  logic        bs_start,                   // level request from the loader
    output logic        spi_ss,
    output logic        wbuf_rd_en,
    output logic        rbuf_wr_en,
    output logic        bs_bit_valid,
    output logic        end_bitstream,
    output logic [11:0] bit_addr
);

    // counter has to reach BITSTREAM_BITS-1
    localparam int BS_CNT_W = (BITSTREAM_BITS > 1) ? $clog2(BITSTREAM_BITS) : 1;
    localparam logic [BS_CNT_W-1:0] BS_CNT_LAST = BS_CNT_W'(BITSTREAM_BITS - 1);
    localparam logic [11:0] BS_CMD_END = 12'(BS_CMD_BITS);
    localparam logic [NUM_STATES-1:0] IDLE_ONEHOT = NUM_STATES'(1) << IDLE;

    // ==============================
    // command latch
    // ==============================

    logic        cmd_accept;
    logic [8:0]  wr_bytes_q;                        // held for the whole transaction
    logic [8:0]  rd_bytes_q;
    logic [11:0] wr_bits_end;                       // counter value in the last send cycle
    logic [11:0] rd_bits_last;                      // counter value in the last receive cycle

    logic [NUM_STATES-1:0] state;
    logic [NUM_STATES-1:0] state_nxt;

    // host loses to a busy loader, zero write count is not a transaction
    assign cmd_accept = state[IDLE] && cmd_strobe && !loader_busy
                        && (cmd_word.fields.wr_bytes != 9'd0);

    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            wr_bytes_q <= cmd_word.fields.wr_bytes;
            rd_bytes_q <= cmd_word.fields.rd_bytes;
        end
    end

    // counter is one ahead of mosi since the buffer read is registered
    assign wr_bits_end  = {wr_bytes_q, 3'b000};
    assign rd_bits_last = {rd_bytes_q, 3'b000} - 12'd1;

    // ==============================
    // bit and bitstream counters
    // ==============================

    logic                bit_cnt_clr;               // held at zero outside the shift phases
    logic [11:0]         bit_cnt;
    logic [BS_CNT_W-1:0] bs_cnt;

    assign bit_cnt_clr = state[IDLE] || state[FINISH_CMD] || state[FINISH_BS_CMD]
                         || state[READ_BS] || state[BS_DONE];

    always_ff @(posedge clk) begin
        if (bit_cnt_reset || bit_cnt_clr) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 12'd1;
        end
    end

    // only runs while the bitstream streams out
    always_ff @(posedge clk) begin
        if (bit_cnt_reset || !state[READ_BS]) begin
            bs_cnt <= '0;
        end else begin
            bs_cnt <= bs_cnt + 1'b1;
        end
    end

    // ==============================
    // state machine
    // ==============================

    always_ff @(posedge clk) begin
        if (bit_cnt_reset) begin
            state <= IDLE_ONEHOT;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = '0;                             // exactly one bit set below
        case (1'b1)
            state[IDLE]: begin
                if (cmd_accept) begin
                    state_nxt[START_CMD] = 1'b1;
                end else if (bs_start) begin
                    state_nxt[START_BS_CMD] = 1'b1;
                end else begin
                    state_nxt[IDLE] = 1'b1;
                end
            end

            // ---- host transaction
            state[START_CMD]: state_nxt[SEND_CMD] = 1'b1;
            state[SEND_CMD]: begin
                if (bit_cnt == wr_bits_end) begin
                    state_nxt[FINISH_CMD] = 1'b1;
                end else begin
                    state_nxt[SEND_CMD] = 1'b1;
                end
            end
            state[FINISH_CMD]: begin
                if (rd_bytes_q == 9'd0) begin       // nothing to capture
                    state_nxt[IDLE] = 1'b1;
                end else begin
                    state_nxt[RECEIVE_RSP] = 1'b1;
                end
            end
            state[RECEIVE_RSP]: begin
                if (bit_cnt == rd_bits_last) begin
                    state_nxt[IDLE] = 1'b1;
                end else begin
                    state_nxt[RECEIVE_RSP] = 1'b1;
                end
            end

            // ---- bitstream read, fixed 4-byte command
            state[START_BS_CMD]: state_nxt[SEND_BS_CMD] = 1'b1;
            state[SEND_BS_CMD]: begin
                if (bit_cnt == BS_CMD_END) begin
                    state_nxt[FINISH_BS_CMD] = 1'b1;
                end else begin
                    state_nxt[SEND_BS_CMD] = 1'b1;
                end
            end
            state[FINISH_BS_CMD]: state_nxt[READ_BS] = 1'b1;
            state[READ_BS]: begin
                if (bs_cnt == BS_CNT_LAST) begin
                    state_nxt[BS_DONE] = 1'b1;
                end else begin
                    state_nxt[READ_BS] = 1'b1;
                end
            end
            state[BS_DONE]: state_nxt[IDLE] = 1'b1;

            default: state_nxt[IDLE] = 1'b1;        // lost one-hot, fall back to idle
        endcase
    end

    // ==============================
    // outputs
    // ==============================

    // buffer read runs one cycle ahead of mosi, so START already reads
    assign wbuf_rd_en = state[START_CMD] || state[SEND_CMD]
                        || state[START_BS_CMD] || state[SEND_BS_CMD];
    assign rbuf_wr_en = state[RECEIVE_RSP];

    // select is released whenever no transfer is on the wire
    assign spi_ss = state[IDLE] || state[START_CMD] || state[START_BS_CMD] || state[BS_DONE];

    assign bs_bit_valid  = state[READ_BS];
    assign end_bitstream = state[BS_DONE];          // one cycle only
    assign bit_addr      = bit_cnt;                 // same index for both buffers

endmodule

// ==== source/spi_flash_intf.sv ====
`timescale 1ns/1ps

module spi_flash_intf import flash_pkg::*; #(
    parameter int BUF_ADDR_W     = 7,               // 128 words per buffer
    parameter int BITSTREAM_BITS = 24090592
) (
    input  logic                  clk,
    input  logic                  bit_cnt_reset,

    // host side
    input  flash_cmd_u            cmd_word,
    input  logic                  cmd_strobe,
    input  logic                  wbuf_wr_en,
    input  logic [BUF_ADDR_W-1:0] wbuf_wr_addr,
    input  logic [31:0]           wbuf_wr_data,
    input  logic                  rbuf_rd_en,
    input  logic [BUF_ADDR_W-1:0] rbuf_rd_addr,
    output logic [31:0]           rbuf_rd_data,

    // loader side
    input  logic                  loader_busy,
    input  logic                  loader_wr_en,
    input  logic [BUF_ADDR_W-1:0] loader_wr_addr,
    input  logic [31:0]           loader_wr_data,
    input  logic                  bs_start,
    output logic                  bs_bit,
    output logic                  bs_bit_valid,
    output logic                  end_bitstream,

    // flash pins
    output logic                  spi_clk,
    output logic                  spi_mosi,
    input  logic                  spi_miso,
    output logic                  spi_ss
);

    logic        wbuf_rd_en;
    logic        rbuf_wr_en;
    logic [11:0] bit_addr;
    logic        wbuf_bit;

    // flash samples mosi mid-bit on the rising edge of spi_clk
    assign spi_clk  = ~clk;
    assign spi_mosi = wbuf_bit;
    assign bs_bit   = spi_miso;                     // qualified by bs_bit_valid

    flash_sequencer #(
        .BITSTREAM_BITS (BITSTREAM_BITS)
    ) u_sequencer (
        .clk           (clk),
        .bit_cnt_reset (bit_cnt_reset),
        .cmd_word      (cmd_word),
        .cmd_strobe    (cmd_strobe),
        .loader_busy   (loader_busy),
        .bs_start      (bs_start),
        .spi_ss        (spi_ss),
        .wbuf_rd_en    (wbuf_rd_en),
        .rbuf_wr_en    (rbuf_wr_en),
        .bs_bit_valid  (bs_bit_valid),
        .end_bitstream (end_bitstream),
        .bit_addr      (bit_addr)
    );

    spi_bit_buffers #(
        .BUF_ADDR_W (BUF_ADDR_W)
    ) u_buffers (
        .clk            (clk),
        .loader_busy    (loader_busy),
        .host_wr_en     (wbuf_wr_en),
        .host_wr_addr   (wbuf_wr_addr),
        .host_wr_data   (wbuf_wr_data),
        .loader_wr_en   (loader_wr_en),
        .loader_wr_addr (loader_wr_addr),
        .loader_wr_data (loader_wr_data),
        .wbuf_rd_en     (wbuf_rd_en),
        .bit_addr       (bit_addr),
        .wbuf_bit       (wbuf_bit),
        .rbuf_wr_en     (rbuf_wr_en),
        .rbuf_bit_in    (spi_miso),                 // miso straight into the read buffer
        .rbuf_rd_en     (rbuf_rd_en),
        .rbuf_rd_addr   (rbuf_rd_addr),
        .rbuf_rd_data   (rbuf_rd_data)
    );

endmodule

// ==== verification/spi_flash_properties.sv ====
`timescale 1ns/1ps

module spi_flash_properties import flash_pkg::*; (
    input logic                  clk,
    input logic                  bit_cnt_reset,
    input logic [NUM_STATES-1:0] state,             // one-hot vector of the sequencer
    input logic                  spi_ss,
    input logic                  end_bitstream
);

    int fail_count = 0;                             // assertion failures so far

    // ==============================
    // sequencer rules
    // ==============================

    a_state_onehot: assert property (@(posedge clk) disable iff (bit_cnt_reset)
        $onehot(state))
        else begin
            $error("sequencer state vector is not one-hot: %b", state);
            fail_count++;
        end

    // no select while idle or while the buffer read is primed
    a_ss_released: assert property (@(posedge clk) disable iff (bit_cnt_reset)
        (state[IDLE] || state[START_CMD] || state[START_BS_CMD]) |-> spi_ss)
        else begin
            $error("spi_ss low outside a transfer");
            fail_count++;
        end

    a_end_single: assert property (@(posedge clk) disable iff (bit_cnt_reset)
        end_bitstream |=> !end_bitstream)
        else begin
            $error("end_bitstream longer than one cycle");
            fail_count++;
        end

endmodule

bind flash_sequencer spi_flash_properties u_props (
    .clk           (clk),
    .bit_cnt_reset (bit_cnt_reset),
    .state         (state),
    .spi_ss        (spi_ss),
    .end_bitstream (end_bitstream)
);

// ==== verification/spi_flash_tb.sv ====
`timescale 1ns/1ps

module spi_flash_tb import flash_pkg::*; ();

    localparam int BS_BITS = 96;                    // short bitstream for simulation
    localparam int AW      = 7;

    logic          clk            = 1'b0;
    logic          bit_cnt_reset  = 1'b1;
    flash_cmd_u    cmd_word       = '0;
    logic          cmd_strobe     = 1'b0;
    logic          wbuf_wr_en     = 1'b0;
    logic [AW-1:0] wbuf_wr_addr   = '0;
    logic [31:0]   wbuf_wr_data   = '0;
    logic          rbuf_rd_en     = 1'b0;
    logic [AW-1:0] rbuf_rd_addr   = '0;
    logic [31:0]   rbuf_rd_data;
    logic          loader_busy    = 1'b0;
    logic          loader_wr_en   = 1'b0;
    logic [AW-1:0] loader_wr_addr = '0;
    logic [31:0]   loader_wr_data = '0;
    logic          bs_start       = 1'b0;
    logic          bs_bit;
    logic          bs_bit_valid;
    logic          end_bitstream;
    logic          spi_clk;
    logic          spi_mosi;
    logic          spi_miso       = 1'b0;
    logic          spi_ss;

    // current stim record
    int            fd;
    int            mode;
    flash_cmd_u    rec_cmd;
    logic [31:0]   buf_words[$];
    logic [31:0]   miso_words[$];                   // first bit in bit 31
    logic [31:0]   exp_words[$];

    // flash responder
    int            send_bits;                       // mosi bits kept before the turnaround
    int            ss_low_cnt;
    logic          mosi_bits [4096];
    logic          bs_bits [4096];
    int            bs_cnt;
    int            end_cnt;
    logic          valid_seen = 1'b0;

    int            checks      = 0;
    int            errors      = 0;
    int            cycles      = 0;
    int            cycle_limit = 40;                // reset plus margin, grows per record

    spi_flash_intf #(
        .BUF_ADDR_W     (AW),
        .BITSTREAM_BITS (BS_BITS)
    ) DUT (.*);

    always #20 clk = ~clk;                          // 40 ns period

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("TIMEOUT after %0d cycles, the DUT did not finish a transfer", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ==============================
    // flash responder
    // ==============================

    // mosi is sampled on the rising spi_clk, miso shifts out on the falling clk
    always @(posedge spi_clk) begin
        valid_seen = 1'b0;
        if (end_bitstream) end_cnt = end_cnt + 1;
        if (!spi_ss) begin
            valid_seen = bs_bit_valid;
            if (ss_low_cnt < send_bits) begin
                mosi_bits[ss_low_cnt] = spi_mosi;
            end else if (ss_low_cnt > send_bits) begin   // one turnaround cycle skipped
                spi_miso <= miso_at(ss_low_cnt - send_bits - 1);
            end
            ss_low_cnt = ss_low_cnt + 1;
        end else begin
            spi_miso <= 1'b0;
        end
    end

    // bs_bit is only a wire of miso, so it is stable at the rising edge
    always @(posedge clk) begin
        if (valid_seen && bs_cnt < 4096) begin
            bs_bits[bs_cnt] = bs_bit;
            bs_cnt = bs_cnt + 1;
        end
    end

    function automatic logic miso_at(input int i);
        logic [31:0] w;
        w = miso_words[i / 32];
        return w[31 - (i % 32)];
    endfunction

    function automatic logic [31:0] word_of(input logic bits [4096], input int i);
        logic [31:0] w;
        for (int b = 0; b < 32; b++) begin
            w[31 - b] = bits[32 * i + b];           // first bit on the wire -> bit 31
        end
        return w;
    endfunction

    // ==============================
    // compare tasks
    // ==============================

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %08h expected %08h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_cmd(input string name, input flash_cmd_u got, input flash_cmd_u exp);
        checks++;
        if (got.raw !== exp.raw) begin
            errors++;
            $display("FAIL %0t %s got %08h expected %08h (wr %0d/%0d rd %0d/%0d)", $time,
                     name, got.raw, exp.raw, got.fields.wr_bytes, exp.fields.wr_bytes,
                     got.fields.rd_bytes, exp.fields.rd_bytes);
        end
    endtask

    // ==============================
    // stim file and bus tasks
    // ==============================

    // next data line, '#' lines and blank lines skipped
    task automatic read_line(input byte tag, output string body, output logic found);
        string line;
        found = 1'b0;
        body  = "";
        while (!found && fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                found = 1'b1;
                body  = line.substr(1, line.len() - 1);
                if (line.getc(0) != tag) begin
                    errors++;
                    $display("stim file out of step, wanted a %c line but read: %s", tag, line);
                end
            end
        end
    endtask

    task automatic read_word(input byte tag, output logic [31:0] w);
        string body;
        logic  found;
        w = '0;
        read_line(tag, body, found);
        if (!found) begin
            errors++;
            $display("stim file ended inside a record, no %c line left", tag);
        end
        void'($sscanf(body, "%h", w));
    endtask

    task automatic load_buffer(input logic by_loader);
        for (int i = 0; i < buf_words.size(); i++) begin
            @(negedge clk);
            wbuf_wr_en     = 1'b1;
            wbuf_wr_addr   = AW'(i);
            wbuf_wr_data   = by_loader ? ~buf_words[i] : buf_words[i];   // dropped when busy
            loader_wr_en   = by_loader;
            loader_wr_addr = AW'(i);
            loader_wr_data = buf_words[i];
        end
        @(negedge clk);
        wbuf_wr_en   = 1'b0;
        loader_wr_en = 1'b0;
    endtask

    task automatic issue_cmd();
        @(negedge clk);
        cmd_word   = rec_cmd;
        cmd_strobe = 1'b1;
        @(negedge clk);
        cmd_strobe = 1'b0;
    endtask

    task automatic wait_ss(input logic level);
        while (spi_ss !== level) @(negedge clk);    // timer above bounds this
    endtask

    task automatic watch_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            check_bit("spi_ss", spi_ss, 1'b1);
        end
    endtask

    task automatic read_back();
        for (int i = 0; i < exp_words.size(); i++) begin
            @(negedge clk);
            rbuf_rd_en   = 1'b1;
            rbuf_rd_addr = AW'(i);
            @(negedge clk);                         // data one cycle after the enable
            rbuf_rd_en = 1'b0;
            check_word($sformatf("rbuf_rd_data[%0d]", i), rbuf_rd_data, exp_words[i]);
        end
    endtask

    // ==============================
    // transactions
    // ==============================

    task automatic run_host_cmd();
        int          wr;
        int          rd;
        int          rem;
        logic [31:0] mask;
        wr         = int'(rec_cmd.fields.wr_bytes);
        rd         = int'(rec_cmd.fields.rd_bytes);
        send_bits  = 8 * wr;
        ss_low_cnt = 0;
        issue_cmd();
        if (wr == 0) begin
            watch_idle(16);                         // zero write count starts nothing
        end else begin
            wait_ss(1'b0);
            wait_ss(1'b1);
            check_word("spi_ss low cycles", ss_low_cnt, 8 * wr + 1 + 8 * rd);
            for (int i = 0; 4 * i < wr; i++) begin
                rem  = wr - 4 * i;                  // bytes of this word on the wire
                mask = (rem >= 4) ? 32'hFFFF_FFFF : ~(32'hFFFF_FFFF >> (8 * rem));
                check_word($sformatf("spi_mosi word %0d", i),
                           word_of(mosi_bits, i) & mask, buf_words[i] & mask);
            end
            read_back();
        end
    endtask

    task automatic run_bitstream();
        flash_cmd_u got_cmd;
        flash_cmd_u exp_cmd;
        send_bits  = BS_CMD_BITS;
        ss_low_cnt = 0;
        bs_cnt     = 0;
        end_cnt    = 0;
        @(negedge clk);
        bs_start = 1'b1;                            // dropped before BS_DONE can restart it
        @(negedge clk);
        bs_start = 1'b0;
        wait_ss(1'b0);
        wait_ss(1'b1);
        check_bit("end_bitstream", end_bitstream, 1'b1);
        @(negedge clk);
        check_bit("end_bitstream", end_bitstream, 1'b0);
        check_bit("spi_ss", spi_ss, 1'b1);
        check_word("end_bitstream pulses", end_cnt, 1);
        check_word("bs_bit_valid cycles", bs_cnt, BS_BITS);
        check_word("spi_ss low cycles", ss_low_cnt, BS_CMD_BITS + 1 + BS_BITS);
        got_cmd.raw = word_of(mosi_bits, 0);
        exp_cmd.raw = buf_words[0];
        check_cmd("bitstream command", got_cmd, exp_cmd);
        for (int i = 0; i < exp_words.size(); i++) begin
            check_word($sformatf("bs_bit word %0d", i), word_of(bs_bits, i), exp_words[i]);
        end
    endtask

    // ==============================
    // main sequence
    // ==============================

    initial begin
        string       body;
        logic        more;
        logic [31:0] w;
        logic [31:0] cmd_raw;
        int          nbuf;
        int          nmiso;
        int          nexp;
        int          tests;
        int          errs_before;
        tests = 0;
        fd    = $fopen("verification/spi_flash_stim.txt", "r");
        more  = (fd != 0);
        if (fd == 0) begin
            errors++;
            $display("could not open verification/spi_flash_stim.txt");
        end
        repeat (10) @(negedge clk);
        check_bit("spi_ss", spi_ss, 1'b1);          // reset values
        check_bit("end_bitstream", end_bitstream, 1'b0);
        check_bit("bs_bit_valid", bs_bit_valid, 1'b0);
        bit_cnt_reset = 1'b0;
        while (more) begin
            read_line("H", body, more);
            if (more) begin
                void'($sscanf(body, "%h %h %h %h %h", mode, cmd_raw, nbuf, nmiso, nexp));
                rec_cmd.raw = cmd_raw;
                buf_words.delete();
                miso_words.delete();
                exp_words.delete();
                for (int i = 0; i < nbuf; i++) begin
                    read_word("W", w);
                    buf_words.push_back(w);
                end
                for (int i = 0; i < nmiso; i++) begin
                    read_word("M", w);
                    miso_words.push_back(w);
                end
                for (int i = 0; i < nexp; i++) begin
                    read_word("E", w);
                    exp_words.push_back(w);
                end
                // worst case length of this record plus margin
                cycle_limit += 2 * nbuf + 2 * nexp + 8 * int'(rec_cmd.fields.wr_bytes)
                               + 8 * int'(rec_cmd.fields.rd_bytes) + 60
                               + ((mode == 2) ? BS_CMD_BITS + 2 + BS_BITS : 0);
                errs_before = errors;
                tests++;
                if (mode == 0) begin
                    load_buffer(1'b0);
                    run_host_cmd();
                end else begin
                    @(negedge clk);
                    loader_busy = 1'b1;
                    load_buffer(1'b1);
                    if (mode == 1) begin
                        send_bits  = 0;
                        ss_low_cnt = 0;
                        issue_cmd();                // ignored while the loader is busy
                        watch_idle(16);
                        loader_busy = 1'b0;
                        run_host_cmd();
                    end else begin
                        run_bitstream();
                        loader_busy = 1'b0;
                    end
                end
                $display("test %0d mode %0d cmd %08h: %s", tests, mode, rec_cmd.raw,
                         (errors == errs_before) ? "ok" : "errors");
            end
        end
        errors += DUT.u_sequencer.u_props.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && tests > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/spi_flash_stim.txt ====
# H mode cmd nbuf nmiso nexp : record header, mode 0 host, 1 loader takeover, 2 bitstream
# W buffer word, M miso word (first bit in bit 31), E expected read-back or bs_bit word
# host read, 4 bytes out, 8 bytes back
H 0 00040008 1 2 2
W 03001000
M A5C30F96
M 12345678
E A5C30F96
E 12345678
# 6 bytes out, partial last word
H 0 00060004 2 1 1
W 0BFFEE00
W 5AC3DEAD
M 3CF0A55A
E 3CF0A55A
# no response bytes
H 0 00050000 2 0 0
W 02000100
W C7000000
# zero write count
H 0 00000004 0 0 0
# loader owns the write port, host strobe ignored
H 1 00080004 2 1 1
W 0B0010A0
W 66995AA5
M F00FC33C
E F00FC33C
# bitstream read, 96 bits
H 2 00000000 1 3 3
W 03400000
M DEADBEEF
M 0F1E2D3C
M 80000001
E DEADBEEF
E 0F1E2D3C
E 80000001
# id read after the bitstream
H 0 00010004 1 1 1
W 9F000000
M EF401800
E EF401800

// ==== compile.f ====
source/flash_pkg.sv
source/spi_bit_buffers.sv
source/flash_sequencer.sv
source/spi_flash_intf.sv
verification/spi_flash_properties.sv
verification/spi_flash_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = spi_flash_tb
FILELIST   = compile.f
OBJ_DIR    = obj_dir
PASS_STR   = Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
